// File: project.f
hw/tlb_pkg.sv
hw/tlb_request_decode.sv
hw/tlb_entry.sv
hw/tlb_hit_select.sv
hw/tlb_entry_read.sv
hw/tlb_addr_map.sv
hw/tlb_top.sv
verif/tlb_properties.sv
verif/tlb_tb.sv

// File: Makefile
# Verilator build and run of the TLB testbench

VERILATOR  ?= verilator
TOP        ?= tlb_tb
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(wildcard hw/*.sv verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tlb_tb.sv
`timescale 1ns/1ps

module tlb_tb;
    import tlb_pkg::*;

    localparam int TLBNUM = 16;
    localparam int IDX_W  = $clog2(TLBNUM);

    typedef struct packed {
        logic             we;
        logic [IDX_W-1:0] w_index;
        word_t            hi;
        word_t            lo0;
        word_t            lo1;
        logic [IDX_W-1:0] r_index;
        logic             op_tlbp;
        logic [1:0]       acc;
        word_t            vaddr;
        logic [2:0]       k0;
        // which output groups this row checks
        logic             chk_rd;
        logic             chk_xlat;
        logic             chk_exc;
        logic             chk_probe;
        word_t            exp_hi;
        word_t            exp_lo0;
        word_t            exp_lo1;
        logic [19:0]      exp_tag;
        logic             exp_uc;
        // refill, invalid, modify
        logic [2:0]       exp_exc;
        word_t            exp_pidx;
    } row_t;

    logic             clk;
    logic             resetn;
    logic [2:0]       i_k0;
    logic             i_we;
    logic [IDX_W-1:0] i_w_index;
    word_t            i_entry_hi;
    word_t            i_entry_lo0;
    word_t            i_entry_lo1;
    logic [IDX_W-1:0] i_r_index;
    logic             i_op_tlbp;
    logic             i_data_ren;
    logic             i_data_wen;
    word_t            i_data_vaddr;
    logic             o_data_uncached;
    logic [19:0]      o_data_tag;
    word_t            o_p_index;
    logic             o_d_refill;
    logic             o_d_invalid;
    logic             o_d_modify;
    word_t            o_r_hi;
    word_t            o_r_lo0;
    word_t            o_r_lo1;

    row_t rows[$];
    int   cur_row;
    int   cycles;
    int   cycle_limit;

    tlb_top #(
        .TLBNUM (TLBNUM)
    ) UUT (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: stimulus table still running after %0d cycles", cycles);
            $display("Test failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %s row %0d: got 0x%h, expected 0x%h", name, cur_row, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add_write(input logic [IDX_W-1:0] idx, input word_t hi, input word_t lo0,
                             input word_t lo1, input word_t e_hi, input word_t e_lo0,
                             input word_t e_lo1);
        row_t r;
        r = '0;
        r.we      = 1'b1;
        r.w_index = idx;
        r.hi      = hi;
        r.lo0     = lo0;
        r.lo1     = lo1;
        // same index on the read port, so the bypass is seen
        r.r_index = idx;
        r.chk_rd  = 1'b1;
        r.exp_hi  = e_hi;
        r.exp_lo0 = e_lo0;
        r.exp_lo1 = e_lo1;
        rows.push_back(r);
    endtask

    task automatic add_read(input logic [IDX_W-1:0] idx, input word_t e_hi, input word_t e_lo0,
                            input word_t e_lo1);
        row_t r;
        r = '0;
        r.r_index = idx;
        r.chk_rd  = 1'b1;
        r.exp_hi  = e_hi;
        r.exp_lo0 = e_lo0;
        r.exp_lo1 = e_lo1;
        rows.push_back(r);
    endtask

    task automatic add_lookup(input word_t hi, input word_t vaddr, input logic [1:0] acc,
                              input logic [2:0] k0, input logic xlat, input logic [19:0] tag,
                              input logic uc, input logic [2:0] exc);
        row_t r;
        r = '0;
        r.hi       = hi;
        r.vaddr    = vaddr;
        r.acc      = acc;
        r.k0       = k0;
        r.chk_xlat = xlat;
        r.chk_exc  = 1'b1;
        r.exp_tag  = tag;
        r.exp_uc   = uc;
        r.exp_exc  = exc;
        rows.push_back(r);
    endtask

    task automatic add_probe(input word_t hi, input word_t pidx);
        row_t r;
        r = '0;
        r.hi        = hi;
        r.op_tlbp   = 1'b1;
        r.chk_probe = 1'b1;
        r.exp_pidx  = pidx;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // reset state
        add_read(4'd0, 32'h0, 32'h0, 32'h0);
        add_read(4'd7, 32'h0, 32'h0, 32'h0);
        add_read(4'd15, 32'h0, 32'h0, 32'h0);
        add_lookup(32'h0, 32'h0, 2'b10, 3'd0, 1'b1, 20'h00000, 1'b1, 3'b010);
        // junk in reserved bits, G only in lo0
        add_write(4'd0, 32'h0040_1F05, 32'hFC48_D15F, 32'h002A_F356,
                  32'h0040_0005, 32'h0048_D15E, 32'h002A_F356);
        // global entry, page0 clean, page1 invalid
        add_write(4'd1, 32'h0080_0022, 32'h0000_445B, 32'h0000_889D,
                  32'h0080_0022, 32'h0000_445B, 32'h0000_889D);
        add_write(4'd5, 32'h0040_0005, 32'h01DD_DDDE, 32'h0,
                  32'h0040_0005, 32'h01DD_DDDE, 32'h0);
        add_read(4'd0, 32'h0040_0005, 32'h0048_D15E, 32'h002A_F356);
        add_read(4'd1, 32'h0080_0022, 32'h0000_445B, 32'h0000_889D);
        add_read(4'd5, 32'h0040_0005, 32'h01DD_DDDE, 32'h0);
        add_read(4'd2, 32'h0, 32'h0, 32'h0);
        // mapped translation
        add_lookup(32'h05, 32'h0040_0000, 2'b10, 3'd0, 1'b1, 20'h12345, 1'b0, 3'b000);
        add_lookup(32'h05, 32'h0040_1000, 2'b10, 3'd0, 1'b1, 20'h0ABCD, 1'b1, 3'b000);
        add_lookup(32'h05, 32'h0040_1234, 2'b01, 3'd0, 1'b1, 20'h0ABCD, 1'b1, 3'b000);
        add_lookup(32'h06, 32'h0040_0000, 2'b10, 3'd0, 1'b0, 20'h0, 1'b0, 3'b100);
        add_lookup(32'h77, 32'h0080_0000, 2'b10, 3'd0, 1'b1, 20'h00111, 1'b0, 3'b000);
        // exceptions
        add_lookup(32'h05, 32'h1000_0000, 2'b01, 3'd0, 1'b0, 20'h0, 1'b0, 3'b100);
        add_lookup(32'h05, 32'hC000_0000, 2'b10, 3'd0, 1'b0, 20'h0, 1'b0, 3'b100);
        add_lookup(32'h22, 32'h0080_1000, 2'b10, 3'd0, 1'b1, 20'h00222, 1'b0, 3'b010);
        add_lookup(32'h22, 32'h0080_1000, 2'b01, 3'd0, 1'b1, 20'h00222, 1'b0, 3'b010);
        add_lookup(32'h22, 32'h0080_0000, 2'b01, 3'd0, 1'b1, 20'h00111, 1'b0, 3'b001);
        add_lookup(32'h22, 32'h0080_0000, 2'b10, 3'd0, 1'b1, 20'h00111, 1'b0, 3'b000);
        // unmapped windows, all misses
        add_lookup(32'h44, 32'h8123_4567, 2'b11, 3'd3, 1'b1, 20'h01234, 1'b0, 3'b000);
        add_lookup(32'h44, 32'h8123_4567, 2'b10, 3'd2, 1'b1, 20'h01234, 1'b1, 3'b000);
        add_lookup(32'h44, 32'hBFC0_0000, 2'b10, 3'd3, 1'b1, 20'h1FC00, 1'b1, 3'b000);
        add_lookup(32'h44, 32'hA000_1000, 2'b01, 3'd3, 1'b1, 20'h00001, 1'b1, 3'b000);
        // probe, entries 0 and 5 both match the first one
        add_probe(32'h0040_0005, 32'h0000_0000);
        add_probe(32'h0080_0099, 32'h0000_0001);
        add_probe(32'h0000_0000, 32'h0000_0002);
        add_probe(32'h7000_0005, 32'h8000_0000);
    endtask

    task automatic apply_row(input row_t r);
        i_we         = r.we;
        i_w_index    = r.w_index;
        i_entry_hi   = r.hi;
        i_entry_lo0  = r.lo0;
        i_entry_lo1  = r.lo1;
        i_r_index    = r.r_index;
        i_op_tlbp    = r.op_tlbp;
        i_data_ren   = r.acc[1];
        i_data_wen   = r.acc[0];
        i_data_vaddr = r.vaddr;
        i_k0         = r.k0;
    endtask

    task automatic check_row(input row_t r);
        if (r.chk_rd) begin
            check_value("o_r_hi", o_r_hi, r.exp_hi);
            check_value("o_r_lo0", o_r_lo0, r.exp_lo0);
            check_value("o_r_lo1", o_r_lo1, r.exp_lo1);
        end
        if (r.chk_xlat) begin
            check_value("o_data_tag", 32'(o_data_tag), 32'(r.exp_tag));
            check_value("o_data_uncached", 32'(o_data_uncached), 32'(r.exp_uc));
        end
        if (r.chk_exc) begin
            check_value("o_d_refill", 32'(o_d_refill), 32'(r.exp_exc[2]));
            check_value("o_d_invalid", 32'(o_d_invalid), 32'(r.exp_exc[1]));
            check_value("o_d_modify", 32'(o_d_modify), 32'(r.exp_exc[0]));
        end
        if (r.chk_probe) begin
            check_value("o_p_index", o_p_index, r.exp_pidx);
        end
    endtask

    initial begin
        cycles  = 0;
        cur_row = 0;
        resetn  = 1'b0;
        apply_row('0);
        build_table();
        cycle_limit = rows.size() + 20;
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        foreach (rows[n]) begin
            cur_row = n;
            apply_row(rows[n]);
            // sample just before the next edge
            #7;
            check_row(rows[n]);
            @(posedge clk);
            #1;
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: verif/tlb_properties.sv
`timescale 1ns/1ps

module tlb_properties (
    input logic           clk,
    input logic           resetn,
    input tlb_pkg::word_t i_data_vaddr,
    input logic           i_data_ren,
    input logic           i_data_wen,
    input logic           o_d_refill,
    input logic           o_d_invalid,
    input logic           o_d_modify
);
    import tlb_pkg::*;

    logic unmapped;
    logic any_exc;

    assign unmapped = (i_data_vaddr[31:29] == SEG_KSEG0) ||
                      (i_data_vaddr[31:29] == SEG_KSEG1);
    assign any_exc  = o_d_refill || o_d_invalid || o_d_modify;

    // at most one exception per access
    exc_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0({o_d_refill, o_d_invalid, o_d_modify}))
        else $error("more than one data exception raised at once");

    unmapped_quiet: assert property (@(posedge clk) disable iff (!resetn)
        unmapped |-> !any_exc)
        else $error("exception raised in kseg0/kseg1");

    idle_quiet: assert property (@(posedge clk) disable iff (!resetn)
        !(i_data_ren || i_data_wen) |-> !any_exc)
        else $error("exception raised with no read or write");

endmodule

bind tlb_top tlb_properties u_properties (
    .clk          (clk),
    .resetn       (resetn),
    .i_data_vaddr (i_data_vaddr),
    .i_data_ren   (i_data_ren),
    .i_data_wen   (i_data_wen),
    .o_d_refill   (o_d_refill),
    .o_d_invalid  (o_d_invalid),
    .o_d_modify   (o_d_modify)
);

// File: hw/tlb_top.sv
`timescale 1ns/1ps

module tlb_top #(
    parameter int TLBNUM = 16
) (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic [tlb_pkg::CACHE_W-1:0]  i_k0,
    // indexed write
    input  logic                         i_we,
    input  logic [$clog2(TLBNUM)-1:0]    i_w_index,
    input  tlb_pkg::word_t               i_entry_hi,
    input  tlb_pkg::word_t               i_entry_lo0,
    input  tlb_pkg::word_t               i_entry_lo1,
    // indexed read
    input  logic [$clog2(TLBNUM)-1:0]    i_r_index,
    // data-side lookup and probe
    input  logic                         i_op_tlbp,
    input  logic                         i_data_ren,
    input  logic                         i_data_wen,
    input  tlb_pkg::word_t               i_data_vaddr,
    output logic                         o_data_uncached,
    output logic [tlb_pkg::PFN_W-1:0]    o_data_tag,
    output tlb_pkg::word_t               o_p_index,
    output logic                         o_d_refill,
    output logic                         o_d_invalid,
    output logic                         o_d_modify,
    output tlb_pkg::word_t               o_r_hi,
    output tlb_pkg::word_t               o_r_lo0,
    output tlb_pkg::word_t               o_r_lo1
);
    import tlb_pkg::*;

    logic [TLBNUM-1:0]         wr_en;
    tlb_entry_t                wr_entry;
    tlb_key_t                  key;
    tlb_entry_t [TLBNUM-1:0]   entries;
    logic [TLBNUM-1:0]         match;
    logic                      hit;
    logic [$clog2(TLBNUM)-1:0] hit_index;
    tlb_page_t                 hit_page;

    tlb_request_decode #(
        .TLBNUM (TLBNUM)
    ) u_decode (
        .i_we         (i_we),
        .i_w_index    (i_w_index),
        .i_entry_hi   (i_entry_hi),
        .i_entry_lo0  (i_entry_lo0),
        .i_entry_lo1  (i_entry_lo1),
        .i_op_tlbp    (i_op_tlbp),
        .i_data_vaddr (i_data_vaddr),
        .o_wr_en      (wr_en),
        .o_wr_entry   (wr_entry),
        .o_key        (key)
    );

    // one compare slice per entry
    for (genvar i = 0; i < TLBNUM; i++) begin : g_entry
        tlb_entry u_entry (
            .clk        (clk),
            .resetn     (resetn),
            .i_wr_en    (wr_en[i]),
            .i_wr_entry (wr_entry),
            .i_key      (key),
            .o_entry    (entries[i]),
            .o_match    (match[i])
        );
    end

    tlb_hit_select #(
        .TLBNUM (TLBNUM)
    ) u_hit_select (
        .i_match   (match),
        .i_entries (entries),
        .i_odd     (key.odd),
        .o_hit     (hit),
        .o_index   (hit_index),
        .o_page    (hit_page)
    );

    tlb_entry_read #(
        .TLBNUM (TLBNUM)
    ) u_entry_read (
        .i_entries  (entries),
        .i_r_index  (i_r_index),
        .i_w_index  (i_w_index),
        .i_we       (i_we),
        .i_wr_entry (wr_entry),
        .o_r_hi     (o_r_hi),
        .o_r_lo0    (o_r_lo0),
        .o_r_lo1    (o_r_lo1)
    );

    tlb_addr_map #(
        .TLBNUM (TLBNUM)
    ) u_addr_map (
        .i_data_vaddr    (i_data_vaddr),
        .i_k0            (i_k0),
        .i_data_ren      (i_data_ren),
        .i_data_wen      (i_data_wen),
        .i_hit           (hit),
        .i_index         (hit_index),
        .i_page          (hit_page),
        .o_data_tag      (o_data_tag),
        .o_data_uncached (o_data_uncached),
        .o_p_index       (o_p_index),
        .o_d_refill      (o_d_refill),
        .o_d_invalid     (o_d_invalid),
        .o_d_modify      (o_d_modify)
    );

endmodule

// File: hw/tlb_addr_map.sv
`timescale 1ns/1ps

module tlb_addr_map #(
    parameter int TLBNUM = 16
) (
    input  tlb_pkg::word_t               i_data_vaddr,
    input  logic [tlb_pkg::CACHE_W-1:0]  i_k0,
    input  logic                         i_data_ren,
    input  logic                         i_data_wen,
    input  logic                         i_hit,
    input  logic [$clog2(TLBNUM)-1:0]    i_index,
    input  tlb_pkg::tlb_page_t           i_page,
    output logic [tlb_pkg::PFN_W-1:0]    o_data_tag,
    output logic                         o_data_uncached,
    output tlb_pkg::word_t               o_p_index,
    output logic                         o_d_refill,
    output logic                         o_d_invalid,
    output logic                         o_d_modify
);
    import tlb_pkg::*;

    logic [2:0] seg;
    logic       kseg0;
    logic       kseg1;
    logic       unmapped;
    logic       access;
    logic       mapped_uc;
    logic       direct_uc;

    assign seg      = i_data_vaddr[31:29];
    assign kseg0    = (seg == SEG_KSEG0);
    assign kseg1    = (seg == SEG_KSEG1);
    assign unmapped = kseg0 || kseg1;

    // direct window drops the top three bits
    assign o_data_tag = unmapped ? {3'b000, i_data_vaddr[28:12]} : i_page.pfn;

    // kseg1 never cached, kseg0 follows k0
    assign direct_uc = kseg1 || (i_k0 != CACHEABLE);
    assign mapped_uc = (i_page.c != CACHEABLE);

    assign o_data_uncached = unmapped ? direct_uc : mapped_uc;

    assign access = i_data_ren || i_data_wen;

    // no translation, so no exceptions in the unmapped windows
    assign o_d_refill  = !unmapped && access && !i_hit;
    assign o_d_invalid = !unmapped && access && i_hit && !i_page.v;
    assign o_d_modify  = !unmapped && i_data_wen && i_hit && i_page.v && !i_page.d;

    // probe result, bit 31 flags a miss
    assign o_p_index = i_hit ? word_t'(i_index) : PROBE_MISS;

endmodule

// File: hw/tlb_entry_read.sv
`timescale 1ns/1ps

module tlb_entry_read #(
    parameter int TLBNUM = 16
) (
    input  tlb_pkg::tlb_entry_t [TLBNUM-1:0] i_entries,
    input  logic [$clog2(TLBNUM)-1:0]        i_r_index,
    input  logic [$clog2(TLBNUM)-1:0]        i_w_index,
    input  logic                             i_we,
    input  tlb_pkg::tlb_entry_t              i_wr_entry,
    output tlb_pkg::word_t                   o_r_hi,
    output tlb_pkg::word_t                   o_r_lo0,
    output tlb_pkg::word_t                   o_r_lo1
);
    import tlb_pkg::*;

    localparam int HI_GAP = WORD_W - VPN2_W - ASID_W;
    localparam int LO_TOP = WORD_W - PFN_W - CACHE_W - 3;

    tlb_entry_t rd_entry;
    logic       bypass;

    // back into EntryLo layout, upper bits zero
    function automatic word_t pack_lo(input tlb_page_t page, input logic g);
        word_t lo;
        lo = {{LO_TOP{1'b0}}, page.pfn, page.c, page.d, page.v, g};
        return lo;
    endfunction

    // a write to the same index shows up in this cycle
    assign bypass   = i_we && (i_w_index == i_r_index);
    assign rd_entry = bypass ? i_wr_entry : i_entries[i_r_index];

    assign o_r_hi  = {rd_entry.vpn2, {HI_GAP{1'b0}}, rd_entry.asid};
    assign o_r_lo0 = pack_lo(rd_entry.page0, rd_entry.g);
    assign o_r_lo1 = pack_lo(rd_entry.page1, rd_entry.g);

endmodule

// File: hw/tlb_hit_select.sv
`timescale 1ns/1ps

module tlb_hit_select #(
    parameter int TLBNUM = 16
) (
    input  logic [TLBNUM-1:0]                i_match,
    input  tlb_pkg::tlb_entry_t [TLBNUM-1:0] i_entries,
    input  logic                             i_odd,
    output logic                             o_hit,
    output logic [$clog2(TLBNUM)-1:0]        o_index,
    output tlb_pkg::tlb_page_t               o_page
);
    import tlb_pkg::*;

    localparam int IDX_W = $clog2(TLBNUM);

    logic [IDX_W-1:0] hit_idx;
    tlb_entry_t       hit_entry;

    // scan downwards so the lowest match is written last
    always_comb begin
        hit_idx = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (i_match[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign hit_entry = i_entries[hit_idx];

    assign o_hit   = |i_match;
    assign o_index = hit_idx;
    // bit 12 picks the odd page
    assign o_page  = i_odd ? hit_entry.page1 : hit_entry.page0;

endmodule

// File: hw/tlb_entry.sv
`timescale 1ns/1ps

module tlb_entry (
    input  logic                clk,
    input  logic                resetn,
    input  logic                i_wr_en,
    input  tlb_pkg::tlb_entry_t i_wr_entry,
    input  tlb_pkg::tlb_key_t   i_key,
    output tlb_pkg::tlb_entry_t o_entry,
    output logic                o_match
);
    import tlb_pkg::*;

    tlb_entry_t entry_q;
    logic       vpn_eq;
    logic       asid_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            entry_q <= '0;
        end else if (i_wr_en) begin
            entry_q <= i_wr_entry;
        end
    end

    assign vpn_eq  = (entry_q.vpn2 == i_key.vpn2);
    // global entries ignore the asid
    assign asid_ok = (entry_q.asid == i_key.asid) || entry_q.g;

    assign o_match = vpn_eq && asid_ok;
    assign o_entry = entry_q;

endmodule

// File: hw/tlb_request_decode.sv
`timescale 1ns/1ps

module tlb_request_decode #(
    parameter int TLBNUM = 16
) (
    input  logic                      i_we,
    input  logic [$clog2(TLBNUM)-1:0] i_w_index,
    input  tlb_pkg::word_t            i_entry_hi,
    input  tlb_pkg::word_t            i_entry_lo0,
    input  tlb_pkg::word_t            i_entry_lo1,
    input  logic                      i_op_tlbp,
    input  tlb_pkg::word_t            i_data_vaddr,
    output logic [TLBNUM-1:0]         o_wr_en,
    output tlb_pkg::tlb_entry_t       o_wr_entry,
    output tlb_pkg::tlb_key_t         o_key
);
    import tlb_pkg::*;

    // EntryLo layout: pfn[25:6] c[5:3] d[2] v[1] g[0]
    function automatic tlb_page_t unpack_lo(input word_t lo);
        tlb_page_t page;
        page.pfn = lo[25:6];
        page.c   = lo[5:3];
        page.d   = lo[2];
        page.v   = lo[1];
        return page;
    endfunction

    // one-hot, all low when no write
    assign o_wr_en = {{(TLBNUM-1){1'b0}}, i_we} << i_w_index;

    assign o_wr_entry.vpn2  = i_entry_hi[31:13];
    assign o_wr_entry.asid  = i_entry_hi[7:0];
    // global only if both halves say so
    assign o_wr_entry.g     = i_entry_lo0[0] & i_entry_lo1[0];
    assign o_wr_entry.page0 = unpack_lo(i_entry_lo0);
    assign o_wr_entry.page1 = unpack_lo(i_entry_lo1);

    // probe searches with EntryHi, lookups with the data address
    assign o_key.vpn2 = i_op_tlbp ? i_entry_hi[31:13] : i_data_vaddr[31:13];
    assign o_key.odd  = i_op_tlbp ? i_entry_hi[12]    : i_data_vaddr[12];
    assign o_key.asid = i_entry_hi[7:0];

endmodule

// File: hw/tlb_pkg.sv
package tlb_pkg;

    // architectural word and field widths
    localparam int WORD_W  = 32;
    localparam int VPN2_W  = 19;
    localparam int ASID_W  = 8;
    localparam int PFN_W   = 20;
    localparam int CACHE_W = 3;

    typedef logic [WORD_W-1:0] word_t;

    // cache attribute meaning cached, noncoherent
    localparam logic [CACHE_W-1:0] CACHEABLE = 3'd3;

    // vaddr[31:29] codes of the unmapped kernel windows
    localparam logic [2:0] SEG_KSEG0 = 3'd4;
    localparam logic [2:0] SEG_KSEG1 = 3'd5;

    // probe result when nothing matches
    localparam word_t PROBE_MISS = 32'h8000_0000;

    // one physical page of a pair
    typedef struct packed {
        logic [PFN_W-1:0]   pfn;
        logic [CACHE_W-1:0] c;
        // dirty, i.e. writable
        logic               d;
        logic               v;
    } tlb_page_t;

    // full stored entry, even page in page0
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    // search key presented to every entry
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        // vaddr bit 12, selects page1
        logic              odd;
    } tlb_key_t;

endpackage
